//--- include/uac_consts.svh
`ifndef UAC_CONSTS_SVH
`define UAC_CONSTS_SVH

// data and byte address width
`define UAC_WORD_W 32

// byte offset inside a word
`define UAC_OFS_W 2

// mask with every data bit written
`define UAC_FULL_MASK 32'hffff_ffff

// address step to the next word
`define UAC_WORD_BYTES 32'd4

`endif

//--- verilog/uac_pkg.sv
`include "uac_consts.svh"

package uac_pkg;

    // widths that carry a meaning
    typedef logic [`UAC_WORD_W-1:0] addr_t;
    typedef logic [`UAC_WORD_W-1:0] data_t;
    typedef logic [`UAC_WORD_W-1:0] mask_t;
    typedef logic [`UAC_OFS_W-1:0]  byte_ofs_t;

    // what the memory port is doing, picks address and write data
    typedef enum logic [2:0] {
        PH_FIRST_READ,
        PH_NEXT_READ,
        PH_WRITE_PASS,
        PH_WRITE_MERGE,
        PH_WRITE_LOW,
        PH_WRITE_HIGH
    } mem_phase_t;

    // access sequencer
    typedef enum logic [3:0] {
        S_IDLE,
        S_FIRST_CMD,
        S_END,
        S_FIRST_RDATA,
        S_NEXT_CMD,
        S_NEXT_RDATA,
        S_WRITE_CMD,
        S_WRITE_LOW_CMD,
        S_WRITE_HIGH_CMD
    } seq_state_t;

    // request, same shape on cpu and memory side
    typedef struct packed {
        logic  valid;
        logic  wen;
        addr_t addr;
        data_t wdata;
        mask_t wmask;
    } mem_req_t;

    // read response, valid only
    typedef struct packed {
        logic  valid;
        data_t rdata;
    } mem_resp_t;

endpackage

//--- verilog/uac_sequencer.sv
module uac_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_valid,
    input  logic               mem_ready,
    input  logic               mem_rvalid,
    input  logic               is_write,
    input  logic               aligned,
    input  logic               full_mask,
    output logic               cpu_ready,
    output logic               cpu_rvalid,
    output logic               capture,
    output logic               mem_valid,
    output logic               mem_wen,
    output logic               load_first,
    output logic               load_next,
    output uac_pkg::mem_phase_t phase
);

    import uac_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;

    // full aligned write needs no read of the old word
    logic pass_write;

    assign pass_write = is_write && aligned && full_mask;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (cpu_valid) begin
                    state_nxt = S_FIRST_CMD;
                end
            end
            S_FIRST_CMD: begin
                // fire and forget for pass write
                if (mem_ready) begin
                    state_nxt = pass_write ? S_END : S_FIRST_RDATA;
                end
            end
            S_FIRST_RDATA: begin
                if (mem_rvalid) begin
                    if (!aligned) begin
                        state_nxt = S_NEXT_CMD;
                    end else if (is_write) begin
                        state_nxt = S_WRITE_CMD;
                    end else begin
                        state_nxt = S_END;
                    end
                end
            end
            S_NEXT_CMD: begin
                if (mem_ready) begin
                    state_nxt = S_NEXT_RDATA;
                end
            end
            S_NEXT_RDATA: begin
                // both words in hand, read done or split write starts
                if (mem_rvalid) begin
                    state_nxt = is_write ? S_WRITE_LOW_CMD : S_END;
                end
            end
            S_WRITE_CMD: begin
                if (mem_ready) begin
                    state_nxt = S_END;
                end
            end
            S_WRITE_LOW_CMD: begin
                if (mem_ready) begin
                    state_nxt = S_WRITE_HIGH_CMD;
                end
            end
            S_WRITE_HIGH_CMD: begin
                if (mem_ready) begin
                    state_nxt = S_END;
                end
            end
            S_END: begin
                state_nxt = S_IDLE;
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // memory command per state, held until ready
    always_comb begin
        mem_valid = 1'b0;
        mem_wen   = 1'b0;
        phase     = PH_FIRST_READ;
        case (state)
            S_FIRST_CMD: begin
                mem_valid = 1'b1;
                mem_wen   = pass_write;
                phase     = pass_write ? PH_WRITE_PASS : PH_FIRST_READ;
            end
            S_NEXT_CMD, S_NEXT_RDATA: begin
                mem_valid = (state == S_NEXT_CMD);
                phase     = PH_NEXT_READ;
            end
            S_WRITE_CMD: begin
                mem_valid = 1'b1;
                mem_wen   = 1'b1;
                phase     = PH_WRITE_MERGE;
            end
            S_WRITE_LOW_CMD: begin
                mem_valid = 1'b1;
                mem_wen   = 1'b1;
                phase     = PH_WRITE_LOW;
            end
            S_WRITE_HIGH_CMD: begin
                mem_valid = 1'b1;
                mem_wen   = 1'b1;
                phase     = PH_WRITE_HIGH;
            end
            default: begin
                // idle port shows the aligned saved address
                phase = PH_FIRST_READ;
            end
        endcase
    end

    // cpu side
    assign cpu_ready = (state == S_IDLE);
    assign capture   = cpu_ready && cpu_valid;

    // read words saved as they arrive
    assign load_first = (state == S_FIRST_RDATA) && mem_rvalid;
    assign load_next  = (state == S_NEXT_RDATA) && mem_rvalid;

    // response with the last word a read needs
    assign cpu_rvalid = !is_write && ((load_first && aligned) || load_next);

endmodule

//--- verilog/uac_datapath.sv
`include "uac_consts.svh"

module uac_datapath (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture,
    input  logic                cpu_wen,
    input  uac_pkg::addr_t      cpu_addr,
    input  uac_pkg::data_t      cpu_wdata,
    input  uac_pkg::mask_t      cpu_wmask,
    input  logic                load_first,
    input  logic                load_next,
    input  uac_pkg::mem_phase_t phase,
    input  uac_pkg::data_t      mem_rdata,
    output logic                is_write,
    output logic                aligned,
    output logic                full_mask,
    output uac_pkg::addr_t      mem_addr,
    output uac_pkg::data_t      mem_wdata,
    output uac_pkg::data_t      cpu_rdata
);

    import uac_pkg::*;

    // saved request
    logic  save_wen;
    addr_t save_addr;
    data_t save_wdata;
    mask_t save_wmask;

    // words read before a merge or an unaligned read
    data_t first_word;
    data_t next_word;

    byte_ofs_t                  ofs;
    logic [`UAC_OFS_W+2:0]      lo_sh;
    logic [`UAC_OFS_W+3:0]      hi_sh;
    addr_t                      addr_lo;
    addr_t                      addr_hi;
    logic [2*`UAC_WORD_W-1:0]   rd_pair;

    // new bits where the mask is set, old bits elsewhere
    function automatic data_t merge_bits(input data_t old_d, input data_t new_d,
                                         input mask_t m);
        return (old_d & ~m) | (new_d & m);
    endfunction

    // control part of the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            save_wen   <= 1'b0;
            save_addr  <= '0;
            save_wmask <= '0;
        end else if (capture) begin
            save_wen   <= cpu_wen;
            save_addr  <= cpu_addr;
            save_wmask <= cpu_wmask;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (capture) begin
            save_wdata <= cpu_wdata;
        end
        if (load_first) begin
            first_word <= mem_rdata;
        end
        if (load_next) begin
            next_word <= mem_rdata;
        end
    end

    assign ofs       = save_addr[`UAC_OFS_W-1:0];
    assign is_write  = save_wen;
    assign aligned   = (ofs == '0);
    assign full_mask = (save_wmask == `UAC_FULL_MASK);

    // byte offset in bits, and the rest of the word for the high lanes
    assign lo_sh = {ofs, 3'b000};
    assign hi_sh = 6'd32 - {1'b0, lo_sh};

    assign addr_lo = {save_addr[`UAC_WORD_W-1:`UAC_OFS_W], {`UAC_OFS_W{1'b0}}};
    assign addr_hi = addr_lo + `UAC_WORD_BYTES;

    // second word only for the next read and the high write
    assign mem_addr = (phase == PH_NEXT_READ || phase == PH_WRITE_HIGH) ? addr_hi : addr_lo;

    always_comb begin
        case (phase)
            PH_WRITE_PASS: mem_wdata = save_wdata;
            PH_WRITE_MERGE: mem_wdata = merge_bits(first_word, save_wdata, save_wmask);
            // low lanes of wdata go above the offset, bytes below kept by zero mask
            PH_WRITE_LOW: mem_wdata = merge_bits(first_word, save_wdata << lo_sh,
                                                 save_wmask << lo_sh);
            // upper lanes of wdata into the bottom of the next word
            PH_WRITE_HIGH: mem_wdata = merge_bits(next_word, save_wdata >> hi_sh,
                                                  save_wmask >> hi_sh);
            default: mem_wdata = '0;
        endcase
    end

    // arriving word above the saved one, shifted down by the offset
    assign rd_pair   = {mem_rdata, first_word} >> lo_sh;
    assign cpu_rdata = aligned ? mem_rdata : rd_pair[`UAC_WORD_W-1:0];

endmodule

//--- verilog/unaligned_access_ctrl.sv
`include "uac_consts.svh"

module unaligned_access_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  uac_pkg::mem_req_t  cpu_req,
    output logic               cpu_ready,
    output uac_pkg::mem_resp_t cpu_resp,
    output uac_pkg::mem_req_t  mem_req,
    input  logic               mem_ready,
    input  uac_pkg::mem_resp_t mem_resp
);

    import uac_pkg::*;

    logic       is_write;
    logic       aligned;
    logic       full_mask;
    logic       capture;
    logic       load_first;
    logic       load_next;
    mem_phase_t phase;

    // order of memory commands
    uac_sequencer u_uac_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_valid  (cpu_req.valid),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_resp.valid),
        .is_write   (is_write),
        .aligned    (aligned),
        .full_mask  (full_mask),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_resp.valid),
        .capture    (capture),
        .mem_valid  (mem_req.valid),
        .mem_wen    (mem_req.wen),
        .load_first (load_first),
        .load_next  (load_next),
        .phase      (phase)
    );

    // addresses, merged writes, assembled reads
    uac_datapath u_uac_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .cpu_wen    (cpu_req.wen),
        .cpu_addr   (cpu_req.addr),
        .cpu_wdata  (cpu_req.wdata),
        .cpu_wmask  (cpu_req.wmask),
        .load_first (load_first),
        .load_next  (load_next),
        .phase      (phase),
        .mem_rdata  (mem_resp.rdata),
        .is_write   (is_write),
        .aligned    (aligned),
        .full_mask  (full_mask),
        .mem_addr   (mem_req.addr),
        .mem_wdata  (mem_req.wdata),
        .cpu_rdata  (cpu_resp.rdata)
    );

    // memory only takes whole words
    assign mem_req.wmask = `UAC_FULL_MASK;

endmodule

//--- tb/unaligned_access_ctrl_sva.sv
`include "uac_consts.svh"

module unaligned_access_ctrl_sva (
    input logic               clk,
    input logic               rst_n,
    input logic               cpu_ready,
    input uac_pkg::mem_resp_t cpu_resp,
    input uac_pkg::mem_req_t  mem_req,
    input logic               mem_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    import uac_pkg::*;

    // command held until the memory takes it
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid && !mem_ready |=> mem_req.valid && $stable(mem_req.wen)
            && $stable(mem_req.addr) && $stable(mem_req.wdata))
        else $error("memory request changed before mem_ready");

    // memory only sees whole words
    a_full_mask: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid |-> mem_req.wmask == `UAC_FULL_MASK)
        else $error("memory write mask is not full");

    a_word_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid |-> mem_req.addr[`UAC_OFS_W-1:0] == '0)
        else $error("memory address is not word aligned");

    // read data only while an access is in flight
    a_resp_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |-> !cpu_resp.valid)
        else $error("cpu response while the bridge is idle");

endmodule

bind unaligned_access_ctrl unaligned_access_ctrl_sva u_unaligned_access_ctrl_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_ready (cpu_ready),
    .cpu_resp  (cpu_resp),
    .mem_req   (mem_req),
    .mem_ready (mem_ready)
);

//--- tb/unaligned_access_ctrl_tb.sv
`include "uac_consts.svh"

module unaligned_access_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import uac_pkg::*;

    localparam int N_ROWS     = 32;
    localparam int CLK_PERIOD = 100;

    // one access with the read data the byte model predicts
    typedef struct packed {
        logic  wen;
        addr_t addr;
        data_t wdata;
        mask_t wmask;
        data_t exp;
    } row_t;

    logic      clk;
    logic      rst_n;
    mem_req_t  cpu_req;
    logic      cpu_ready;
    mem_resp_t cpu_resp;
    mem_req_t  mem_req;
    logic      mem_ready;
    mem_resp_t mem_resp;

    // memory behind the bridge and its reference copy
    logic [7:0] mem_bytes [256];
    logic [7:0] sb_bytes [256];

    row_t rows [N_ROWS];
    int   n_rows;
    int   resp_count;
    int   check_count;
    int   err_count;

    unaligned_access_ctrl u_unaligned_access_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_resp  (cpu_resp),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_resp  (mem_resp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // odd multiplier, every address bit shows in the byte
    function automatic logic [7:0] fill_byte(input int i);
        return 8'(i * 13 + 91);
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            err_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // mask bits take the new data, zero bits keep the old byte
    task automatic add_row(input logic wen, input addr_t addr, input data_t wdata,
                           input mask_t wmask);
        row_t r;
        addr_t a;
        r.wen   = wen;
        r.addr  = addr;
        r.wdata = wdata;
        r.wmask = wmask;
        r.exp   = '0;
        for (int k = 0; k < 4; k++) begin
            a = addr + k;
            if (wen) begin
                sb_bytes[a[7:0]] = (sb_bytes[a[7:0]] & ~wmask[8*k +: 8])
                                   | (wdata[8*k +: 8] & wmask[8*k +: 8]);
            end else begin
                // little endian, lowest address in the low byte
                r.exp[8*k +: 8] = sb_bytes[a[7:0]];
            end
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic run_access(input row_t r);
        data_t got;
        cpu_req.valid = 1'b1;
        cpu_req.wen   = r.wen;
        cpu_req.addr  = r.addr;
        cpu_req.wdata = r.wdata;
        cpu_req.wmask = r.wmask;
        resp_count    = 0;
        // taken on the first edge that finds ready high
        while (!cpu_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        cpu_req = '0;
        if (!r.wen) begin
            // response settled mid cycle
            do begin
                @(negedge clk);
            end while (!cpu_resp.valid);
            got = cpu_resp.rdata;
            check_equal("cpu_resp.rdata", got, r.exp);
        end
        // ready again marks the end of the access
        do begin
            @(posedge clk);
            #1;
        end while (!cpu_ready);
        check_equal("cpu_resp.valid count", resp_count, r.wen ? 0 : 1);
    endtask

    // memory model, one read at a time with 1 to 3 cycles latency
    initial begin
        addr_t a;
        data_t rd_word;
        int    lat;
        logic  pending;
        mem_ready = 1'b0;
        mem_resp  = '0;
        rd_word   = '0;
        lat       = 0;
        pending   = 1'b0;
        forever begin
            // command and ready settled, transfer on the coming edge
            @(negedge clk);
            if (rst_n && mem_req.valid && mem_ready) begin
                for (int k = 0; k < 4; k++) begin
                    a = mem_req.addr + k;
                    if (mem_req.wen) begin
                        mem_bytes[a[7:0]] = (mem_bytes[a[7:0]] & ~mem_req.wmask[8*k +: 8])
                                            | (mem_req.wdata[8*k +: 8]
                                               & mem_req.wmask[8*k +: 8]);
                    end else begin
                        rd_word[8*k +: 8] = mem_bytes[a[7:0]];
                    end
                end
                if (!mem_req.wen) begin
                    assert (!pending && !mem_resp.valid) else begin
                        err_count++;
                        $display("memory read issued while another read is outstanding");
                    end
                    pending = 1'b1;
                    lat     = $urandom % 3;
                end
            end
            @(posedge clk);
            #1;
            // response lasts one cycle
            mem_resp.valid = 1'b0;
            if (pending) begin
                if (lat == 0) begin
                    mem_resp.valid = 1'b1;
                    mem_resp.rdata = rd_word;
                    pending        = 1'b0;
                end else begin
                    lat--;
                end
            end
            mem_ready = ($urandom % 4) != 0;
        end
    end

    // read responses seen per access
    always @(negedge clk) begin
        if (rst_n && cpu_resp.valid) begin
            resp_count++;
        end
    end

    initial begin
        #((N_ROWS * 40 + 20) * CLK_PERIOD);
        $display("watchdog expired, an access never completed");
        $display("checks %0d, errors %0d", check_count, err_count + 1);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h2b66));
        clk         = 1'b0;
        rst_n       = 1'b0;
        cpu_req     = '0;
        n_rows      = 0;
        resp_count  = 0;
        check_count = 0;
        err_count   = 0;
        for (int i = 0; i < 256; i++) begin
            mem_bytes[i] = fill_byte(i);
            sb_bytes[i]  = fill_byte(i);
        end

        // aligned full write and masked write with read-back
        add_row(1'b1, 32'h10, 32'h1234_5678, `UAC_FULL_MASK);
        add_row(1'b0, 32'h10, 32'h0, `UAC_FULL_MASK);
        add_row(1'b1, 32'h20, 32'ha5a5_a5a5, 32'h00ff_0ff0);
        add_row(1'b0, 32'h20, 32'h0, `UAC_FULL_MASK);
        // unaligned writes at each offset, whole words read after
        add_row(1'b1, 32'h31, 32'h1122_3344, `UAC_FULL_MASK);
        add_row(1'b0, 32'h30, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h34, 32'h0, `UAC_FULL_MASK);
        add_row(1'b1, 32'h52, 32'h5566_7788, `UAC_FULL_MASK);
        add_row(1'b0, 32'h50, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h54, 32'h0, `UAC_FULL_MASK);
        add_row(1'b1, 32'h63, 32'h99aa_bbcc, `UAC_FULL_MASK);
        add_row(1'b0, 32'h60, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h64, 32'h0, `UAC_FULL_MASK);
        // be be fe ca ef be ad de, then reads across the word seam
        add_row(1'b1, 32'h40, 32'hcafe_bebe, `UAC_FULL_MASK);
        add_row(1'b1, 32'h44, 32'hdead_beef, `UAC_FULL_MASK);
        add_row(1'b0, 32'h41, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h42, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h43, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h40, 32'h0, `UAC_FULL_MASK);
        // unaligned masked write
        add_row(1'b1, 32'h71, 32'hffff_ffff, 32'h0f0f_0f0f);
        add_row(1'b0, 32'h70, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h74, 32'h0, `UAC_FULL_MASK);
        add_row(1'b0, 32'h73, 32'h0, `UAC_FULL_MASK);
        // rest of the table at random in its own region
        while (n_rows < N_ROWS) begin
            add_row(1'($urandom % 2), 32'h80 + ($urandom % 64), $urandom,
                    ($urandom % 2) ? `UAC_FULL_MASK : $urandom);
        end

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_equal("cpu_ready", cpu_ready, 1);
        check_equal("mem_req.valid", mem_req.valid, 0);
        check_equal("cpu_resp.valid", cpu_resp.valid, 0);

        for (int i = 0; i < n_rows; i++) begin
            run_access(rows[i]);
        end

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
verilog/uac_pkg.sv
verilog/uac_sequencer.sv
verilog/uac_datapath.sv
verilog/unaligned_access_ctrl.sv
tb/unaligned_access_ctrl_sva.sv
tb/unaligned_access_ctrl_tb.sv

//--- Bender.yml
package:
  name: unaligned_access_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/uac_pkg.sv
      - verilog/uac_sequencer.sv
      - verilog/uac_datapath.sv
      - verilog/unaligned_access_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/unaligned_access_ctrl_sva.sv
      - tb/unaligned_access_ctrl_tb.sv
